//--- design/sprite_macros.svh
//----------------------------------------------------------
// sprite geometry and register map
// coordinates are two's complement and SPR_COORD_W bits wide
// register addresses assume a 3 bit address bus
//----------------------------------------------------------
`ifndef SPRITE_MACROS_SVH
`define SPRITE_MACROS_SVH

`define SPR_COORD_W         12      // incl sign bit

// frame geometry in pixels
`define SPR_H_VISIBLE       32
`define SPR_H_TOTAL         40
`define SPR_V_VISIBLE       24      // also the ground line
`define SPR_V_TOTAL         30

// register map
`define SPR_ADDR_START_X    3'd0
`define SPR_ADDR_START_Y    3'd1
`define SPR_ADDR_SIZE_X     3'd2
`define SPR_ADDR_SIZE_Y     3'd3
`define SPR_ADDR_STEP_X     3'd4
`define SPR_ADDR_JUMP_SPEED 3'd5
`define SPR_ADDR_MAX_FALL   3'd6
`define SPR_ADDR_CONTROL    3'd7    // bit 0 requests a reload

// register values after reset
`define SPR_DEF_START_X     4
`define SPR_DEF_START_Y     10
`define SPR_DEF_SIZE_X      4
`define SPR_DEF_SIZE_Y      4
`define SPR_DEF_STEP_X      1
`define SPR_DEF_JUMP_SPEED  4
`define SPR_DEF_MAX_FALL    4

`endif

//--- design/spritePkg.sv
//----------------------------------------------------------
// shared types of the sprite block
// speeds are signed but only small positive values make sense
//----------------------------------------------------------
`default_nettype none

`include "sprite_macros.svh"

package spritePkg;

	typedef logic signed [`SPR_COORD_W-1:0] coordT;   // screen coordinate
	typedef logic        [5:0]              sizeT;    // rect width or height
	typedef logic signed [5:0]              speedT;   // pixels per frame
	typedef logic        [2:0]              regAddrT;
	typedef logic        [11:0]             cfgDataT; // target takes the low bits

	// vertical motion
	typedef enum logic [1:0]
	{
		grounded,
		rising,
		falling
	} jumpStateT;

endpackage

`default_nettype wire

//--- design/frameTiming.sv
//----------------------------------------------------------
// raster scan of a 40x30 frame with a 32x24 visible area
// one pixel per clock and scan restarts at 0,0 after reset
// frameEnd is combinational from the counters
//----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "sprite_macros.svh"

module frameTiming
(
	input  logic              iClk,
	input  logic              rstN,
	output spritePkg::coordT  scanX,
	output spritePkg::coordT  scanY,
	output logic              scanVisible,
	output logic              frameEnd
);

	localparam spritePkg::coordT lastCol = spritePkg::coordT'(`SPR_H_TOTAL - 1);
	localparam spritePkg::coordT lastRow = spritePkg::coordT'(`SPR_V_TOTAL - 1);
	localparam spritePkg::coordT visCols = spritePkg::coordT'(`SPR_H_VISIBLE);
	localparam spritePkg::coordT visRows = spritePkg::coordT'(`SPR_V_VISIBLE);

	logic lineEnd;      // last column of any row
	logic rowWrap;      // last row reached

	assign lineEnd = (scanX == lastCol);
	assign rowWrap = (scanY == lastRow);

	//----------------------------------------------------------
	// scan counters
	//----------------------------------------------------------
	always_ff @(posedge iClk)
	begin
		if (!rstN)
		begin
			scanX <= '0;
			scanY <= '0;
		end
		else if (lineEnd)
		begin
			scanX <= '0;                // new line
			if (rowWrap)
				scanY <= '0;            // new frame
			else
				scanY <= scanY + spritePkg::coordT'(1);
		end
		else
		begin
			scanX <= scanX + spritePkg::coordT'(1);
		end
	end

	// counters never go negative so signed compare is safe
	assign scanVisible = (scanX < visCols) && (scanY < visRows);
	assign frameEnd    = lineEnd && rowWrap;   // col 39 row 29

	// single cycle pulse every 1200 clocks
	frameEndPulse: assert property (@(posedge iClk) disable iff (!rstN)
		frameEnd |=> !frameEnd)
		else $error("frameEnd held for more than one cycle");

endmodule

`default_nettype wire

//--- design/motionRegs.sv
//----------------------------------------------------------
// sprite settings with a valid/ready write port
// writes stall for the frame-end cycle only
// reloadReq holds until the next frame end
//----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "sprite_macros.svh"

module motionRegs
(
	input  logic                iClk,
	input  logic                rstN,
	input  logic                cfgValid,
	input  spritePkg::regAddrT  cfgAddr,
	input  spritePkg::cfgDataT  cfgData,
	input  logic                frameEnd,
	output logic                cfgReady,
	output spritePkg::coordT    startX,
	output spritePkg::coordT    startY,
	output spritePkg::sizeT     sizeX,
	output spritePkg::sizeT     sizeY,
	output spritePkg::speedT    stepX,
	output spritePkg::speedT    jumpSpeed,
	output spritePkg::speedT    maxFall,
	output logic                reloadReq
);

	logic wrEn;     // handshake completes

	assign cfgReady = !frameEnd;            // settings frozen in update cycle
	assign wrEn     = cfgValid && cfgReady;

	//----------------------------------------------------------
	// setting registers
	//----------------------------------------------------------
	always_ff @(posedge iClk)
	begin
		if (!rstN)
		begin
			startX    <= spritePkg::coordT'(`SPR_DEF_START_X);
			startY    <= spritePkg::coordT'(`SPR_DEF_START_Y);
			sizeX     <= spritePkg::sizeT'(`SPR_DEF_SIZE_X);
			sizeY     <= spritePkg::sizeT'(`SPR_DEF_SIZE_Y);
			stepX     <= spritePkg::speedT'(`SPR_DEF_STEP_X);
			jumpSpeed <= spritePkg::speedT'(`SPR_DEF_JUMP_SPEED);
			maxFall   <= spritePkg::speedT'(`SPR_DEF_MAX_FALL);
		end
		else if (wrEn)
		begin
			case (cfgAddr)
				`SPR_ADDR_START_X:    startX    <= $signed(cfgData);
				`SPR_ADDR_START_Y:    startY    <= $signed(cfgData);
				`SPR_ADDR_SIZE_X:     sizeX     <= cfgData[5:0];
				`SPR_ADDR_SIZE_Y:     sizeY     <= cfgData[5:0];
				`SPR_ADDR_STEP_X:     stepX     <= $signed(cfgData[5:0]);
				`SPR_ADDR_JUMP_SPEED: jumpSpeed <= $signed(cfgData[5:0]);
				`SPR_ADDR_MAX_FALL:   maxFall   <= $signed(cfgData[5:0]);
				default:              ;         // control has no storage
			endcase
		end
	end

	// reload flag, consumed by the next position update
	always_ff @(posedge iClk)
	begin
		if (!rstN)
			reloadReq <= 1'b0;
		else if (frameEnd)
			reloadReq <= 1'b0;
		else if (wrEn && (cfgAddr == `SPR_ADDR_CONTROL) && cfgData[0])
			reloadReq <= 1'b1;
	end

	// master side of the handshake
	requestHeld: assert property (@(posedge iClk) disable iff (!rstN)
		(cfgValid && !cfgReady) |=> (cfgValid && $stable(cfgAddr) && $stable(cfgData)))
		else $error("cfg request dropped or changed while stalled");

endmodule

`default_nettype wire

//--- design/squarePosGen.sv
//----------------------------------------------------------
// moves the sprite rectangle once per frame
// no horizontal clamp so edges may go negative
// ground line is the first row below the visible area
//----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "sprite_macros.svh"

module squarePosGen
(
	input  logic              iClk,
	input  logic              rstN,
	input  logic              frameEnd,
	input  logic              reloadReq,
	input  logic              moveLeft,
	input  logic              moveRight,
	input  logic              jumpPress,
	input  spritePkg::coordT  startX,
	input  spritePkg::coordT  startY,
	input  spritePkg::sizeT   sizeX,
	input  spritePkg::sizeT   sizeY,
	input  spritePkg::speedT  stepX,
	input  spritePkg::speedT  jumpSpeed,
	input  spritePkg::speedT  maxFall,
	output logic              posValid,
	output spritePkg::coordT  leftX,
	output spritePkg::coordT  rightX,
	output spritePkg::coordT  topY,
	output spritePkg::coordT  bottomY
);

	localparam spritePkg::coordT groundY = spritePkg::coordT'(`SPR_V_VISIBLE);
	localparam spritePkg::coordT defLeft = spritePkg::coordT'(`SPR_DEF_START_X);
	localparam spritePkg::coordT defTop  = spritePkg::coordT'(`SPR_DEF_START_Y);

	spritePkg::jumpStateT jumpState;
	spritePkg::jumpStateT nextState;
	spritePkg::speedT     speed;        // magnitude in current direction
	spritePkg::speedT     nextSpeed;
	spritePkg::speedT     riseSpeed;
	spritePkg::speedT     fallSpeed;
	spritePkg::coordT     nextLeft;
	spritePkg::coordT     nextTop;
	spritePkg::coordT     probeBottom;  // bottom edge before landing
	spritePkg::coordT     sizeXExt;
	spritePkg::coordT     sizeYExt;
	spritePkg::coordT     stepExt;
	spritePkg::coordT     jumpExt;
	logic                 land;

	// size is unsigned so this zero extends
	assign sizeXExt = spritePkg::coordT'(sizeX);
	assign sizeYExt = spritePkg::coordT'(sizeY);
	assign stepExt  = spritePkg::coordT'(stepX);        // sign extend
	assign jumpExt  = spritePkg::coordT'(jumpSpeed);

	// gravity: one unit per frame in each direction
	assign riseSpeed = speed - spritePkg::speedT'(1);
	assign fallSpeed = (speed >= maxFall) ? maxFall : speed + spritePkg::speedT'(1);

	//----------------------------------------------------------
	// next position
	//----------------------------------------------------------
	always_comb
	begin
		nextLeft  = leftX;
		nextTop   = topY;
		nextSpeed = speed;
		nextState = jumpState;

		if (reloadReq)
		begin
			nextLeft  = startX;         // back to start point
			nextTop   = startY;
			nextSpeed = '0;
			nextState = spritePkg::grounded;
		end
		else
		begin
			// both or neither button keeps x
			if (moveLeft && !moveRight)
				nextLeft = leftX - stepExt;
			else if (moveRight && !moveLeft)
				nextLeft = leftX + stepExt;

			case (jumpState)
				spritePkg::grounded:
				begin
					if (jumpPress)
					begin
						nextSpeed = jumpSpeed;
						nextTop   = topY - jumpExt;   // first step up
						nextState = spritePkg::rising;
					end
					else if (bottomY < groundY)
					begin
						nextState = spritePkg::falling; // nothing underneath
					end
				end
				spritePkg::rising:
				begin
					if (riseSpeed <= 0)
					begin
						nextSpeed = '0;                 // apex
						nextState = spritePkg::falling;
					end
					else
					begin
						nextSpeed = riseSpeed;
						nextTop   = topY - spritePkg::coordT'(riseSpeed);
					end
				end
				default:                                // falling
				begin
					nextSpeed = fallSpeed;
					nextTop   = topY + spritePkg::coordT'(fallSpeed);
				end
			endcase
		end

		// landing on the ground line
		probeBottom = nextTop + sizeYExt;
		land = (probeBottom > groundY) ||
			((probeBottom == groundY) && (nextState == spritePkg::falling));
		if (land)
		begin
			nextTop   = groundY - sizeYExt;
			nextSpeed = '0;
			nextState = spritePkg::grounded;
		end
	end

	//----------------------------------------------------------
	// frame update
	//----------------------------------------------------------
	always_ff @(posedge iClk)
	begin
		if (!rstN)
		begin
			posValid  <= 1'b0;
			leftX     <= defLeft;
			topY      <= defTop;
			rightX    <= defLeft + spritePkg::coordT'(`SPR_DEF_SIZE_X);
			bottomY   <= defTop + spritePkg::coordT'(`SPR_DEF_SIZE_Y);
			speed     <= '0;
			jumpState <= spritePkg::grounded;
		end
		else
		begin
			posValid <= frameEnd;       // edges new while high
			if (frameEnd)
			begin
				leftX     <= nextLeft;
				topY      <= nextTop;
				rightX    <= nextLeft + sizeXExt;
				bottomY   <= nextTop + sizeYExt;
				speed     <= nextSpeed;
				jumpState <= nextState;
			end
		end
	end

	// sprite never sinks into the ground
	onGround: assert property (@(posedge iClk) disable iff (!rstN)
		posValid |=> (bottomY <= groundY))
		else $error("bottom edge below ground line");

endmodule

`default_nettype wire

//--- design/squareRaster.sv
//----------------------------------------------------------
// marks scanned pixels inside the sprite rectangle
// left and top edges inclusive and right and bottom exclusive
// all outputs lag the scan by one clock
//----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module squareRaster
(
	input  logic              iClk,
	input  logic              rstN,
	input  spritePkg::coordT  scanX,
	input  spritePkg::coordT  scanY,
	input  logic              scanVisible,
	input  spritePkg::coordT  leftX,
	input  spritePkg::coordT  rightX,
	input  spritePkg::coordT  topY,
	input  spritePkg::coordT  bottomY,
	output spritePkg::coordT  pixelX,
	output spritePkg::coordT  pixelY,
	output logic              pixelVisible,
	output logic              pixelOn
);

	logic insideX;
	logic insideY;

	// signed compares so off-screen edges work
	assign insideX = (scanX >= leftX) && (scanX < rightX);
	assign insideY = (scanY >= topY) && (scanY < bottomY);

	always_ff @(posedge iClk)
	begin
		if (!rstN)
		begin
			pixelVisible <= 1'b0;
			pixelOn      <= 1'b0;
		end
		else
		begin
			pixelVisible <= scanVisible;
			pixelOn      <= scanVisible && insideX && insideY;
		end
		pixelX <= scanX;                // position aligned with pixelOn
		pixelY <= scanY;
	end

endmodule

`default_nettype wire

//--- design/spriteMotionTop.sv
//----------------------------------------------------------
// sprite motion subsystem top
// buttons are levels sampled at frame end
//----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module spriteMotionTop
(
	input  logic                iClk,
	input  logic                rstN,
	input  logic                cfgValid,
	output logic                cfgReady,
	input  spritePkg::regAddrT  cfgAddr,
	input  spritePkg::cfgDataT  cfgData,
	input  logic                moveLeft,
	input  logic                moveRight,
	input  logic                jumpPress,
	output logic                posValid,
	output spritePkg::coordT    leftX,
	output spritePkg::coordT    rightX,
	output spritePkg::coordT    topY,
	output spritePkg::coordT    bottomY,
	output spritePkg::coordT    pixelX,
	output spritePkg::coordT    pixelY,
	output logic                pixelVisible,
	output logic                pixelOn
);

	//----------------------------------------------------------
	// internal nets
	//----------------------------------------------------------
	spritePkg::coordT scanX;
	spritePkg::coordT scanY;
	logic             scanVisible;
	logic             frameEnd;         // update strobe
	spritePkg::coordT startX;
	spritePkg::coordT startY;
	spritePkg::sizeT  sizeX;
	spritePkg::sizeT  sizeY;
	spritePkg::speedT stepX;
	spritePkg::speedT jumpSpeed;
	spritePkg::speedT maxFall;
	logic             reloadReq;

	frameTiming timingInst
	(
		.iClk        (iClk),
		.rstN        (rstN),
		.scanX       (scanX),
		.scanY       (scanY),
		.scanVisible (scanVisible),
		.frameEnd    (frameEnd)
	);

	motionRegs regsInst
	(
		.iClk      (iClk),
		.rstN      (rstN),
		.cfgValid  (cfgValid),
		.cfgAddr   (cfgAddr),
		.cfgData   (cfgData),
		.frameEnd  (frameEnd),
		.cfgReady  (cfgReady),
		.startX    (startX),
		.startY    (startY),
		.sizeX     (sizeX),
		.sizeY     (sizeY),
		.stepX     (stepX),
		.jumpSpeed (jumpSpeed),
		.maxFall   (maxFall),
		.reloadReq (reloadReq)
	);

	squarePosGen posGenInst
	(
		.iClk      (iClk),
		.rstN      (rstN),
		.frameEnd  (frameEnd),
		.reloadReq (reloadReq),
		.moveLeft  (moveLeft),
		.moveRight (moveRight),
		.jumpPress (jumpPress),
		.startX    (startX),
		.startY    (startY),
		.sizeX     (sizeX),
		.sizeY     (sizeY),
		.stepX     (stepX),
		.jumpSpeed (jumpSpeed),
		.maxFall   (maxFall),
		.posValid  (posValid),
		.leftX     (leftX),
		.rightX    (rightX),
		.topY      (topY),
		.bottomY   (bottomY)
	);

	squareRaster rasterInst
	(
		.iClk         (iClk),
		.rstN         (rstN),
		.scanX        (scanX),
		.scanY        (scanY),
		.scanVisible  (scanVisible),
		.leftX        (leftX),
		.rightX       (rightX),
		.topY         (topY),
		.bottomY      (bottomY),
		.pixelX       (pixelX),
		.pixelY       (pixelY),
		.pixelVisible (pixelVisible),
		.pixelOn      (pixelOn)
	);

endmodule

`default_nettype wire

//--- bench/spriteMotionTb.sv
//----------------------------------------------------------
// testbench for the sprite motion top level
// one vector per frame update, read from bench/motion_vectors.txt
// pixel counts assume the 32x24 visible area of the macros
//----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "sprite_macros.svh"

module spriteMotionTb;

	localparam int vecDepth    = 512;                           // 10 words per step
	localparam int frameCycles = `SPR_H_TOTAL * `SPR_V_TOTAL;
	localparam int updateLimit = 2 * frameCycles;               // cycles per wait
	localparam int writeLimit  = 16;

	logic               iClk;
	logic               rstN;
	logic               cfgValid;
	logic               cfgReady;
	spritePkg::regAddrT cfgAddr;
	spritePkg::cfgDataT cfgData;
	logic               moveLeft;
	logic               moveRight;
	logic               jumpPress;
	logic               posValid;
	spritePkg::coordT   leftX;
	spritePkg::coordT   rightX;
	spritePkg::coordT   topY;
	spritePkg::coordT   bottomY;
	spritePkg::coordT   pixelX;
	spritePkg::coordT   pixelY;
	logic               pixelVisible;
	logic               pixelOn;

	logic [11:0] vecMem [0:vecDepth-1];
	int          pixCount;      // pixelOn cycles of the running frame
	int          frameCount;    // latched at posValid
	bit          updateSeen;
	int          stepsRun;
	int          expCol;        // scan column the next pixel sample shows
	int          expRow;

	spriteMotionTop dut_i
	(
		.iClk         (iClk),
		.rstN         (rstN),
		.cfgValid     (cfgValid),
		.cfgReady     (cfgReady),
		.cfgAddr      (cfgAddr),
		.cfgData      (cfgData),
		.moveLeft     (moveLeft),
		.moveRight    (moveRight),
		.jumpPress    (jumpPress),
		.posValid     (posValid),
		.leftX        (leftX),
		.rightX       (rightX),
		.topY         (topY),
		.bottomY      (bottomY),
		.pixelX       (pixelX),
		.pixelY       (pixelY),
		.pixelVisible (pixelVisible),
		.pixelOn      (pixelOn)
	);

	initial
	begin
		iClk = 1'b0;
		forever #4 iClk = ~iClk;    // 8 ns period
	end

	//----------------------------------------------------------
	// helpers
	//----------------------------------------------------------
	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Something failed");
		$fatal(1, "run aborted");
	endtask

	task automatic checkValue(input string name, input int got, input int expected);
		if (got != expected)
			abortRun($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, expected));
	endtask

	// one clock, then sample outputs and drive inputs at edge + 1 ns
	task automatic advanceClock();
		@(posedge iClk);
		#1;
		// pixel outputs trail the scan by one clock
		checkValue("pixelX", int'(pixelX), expCol);
		checkValue("pixelY", int'(pixelY), expRow);
		checkValue("pixelVisible", int'(pixelVisible),
			((expCol < `SPR_H_VISIBLE) && (expRow < `SPR_V_VISIBLE)) ? 1 : 0);
		if (posValid)
		begin
			// update follows the last scan position of the frame
			checkValue("posValidCol", expCol, `SPR_H_TOTAL - 1);
			checkValue("posValidRow", expRow, `SPR_V_TOTAL - 1);
			frameCount = pixCount;  // pixelOn here is the invisible last pixel
			pixCount   = 0;
			updateSeen = 1'b1;
		end
		else if (pixelOn)
		begin
			pixCount++;
		end
		if (expCol == `SPR_H_TOTAL - 1)
		begin
			expCol = 0;
			expRow = (expRow == `SPR_V_TOTAL - 1) ? 0 : expRow + 1;
		end
		else
		begin
			expCol++;
		end
	endtask

	task automatic waitForUpdate();
		int waited;
		waited = 0;
		while (!updateSeen)
		begin
			if (waited >= updateLimit)
				abortRun("timeout: no posValid within two frames");
			advanceClock();
			waited++;
		end
		updateSeen = 1'b0;
	endtask

	task automatic writeReg(input spritePkg::regAddrT addr, input spritePkg::cfgDataT data,
		output int stalls);
		bit accepted;
		stalls   = 0;
		accepted = 1'b0;
		cfgValid = 1'b1;
		cfgAddr  = addr;
		cfgData  = data;
		while (!accepted)
		begin
			if (stalls >= writeLimit)
				abortRun("timeout: cfgReady stayed low during a register write");
			accepted = cfgReady;    // handshake at the coming edge
			advanceClock();
			if (!accepted)
				stalls++;
		end
		cfgValid = 1'b0;
	endtask

	// raise the request inside the frame-end cycle, expect one stall
	task automatic writeAtFrameEnd(input spritePkg::regAddrT addr,
		input spritePkg::cfgDataT data);
		int waited;
		int stalls;
		waited = 0;
		while (cfgReady)
		begin
			if (waited >= updateLimit)
				abortRun("timeout: cfgReady never dropped for a frame end");
			advanceClock();
			waited++;
		end
		writeReg(addr, data, stalls);
		checkValue("cfgStallCycles", stalls, 1);
	endtask

	function automatic int signedEdge(input logic [11:0] word);
		spritePkg::coordT c;
		c = word;
		return c;                   // sign extends
	endfunction

	// rectangle area inside the visible window
	function automatic int clippedArea(input int left, input int right, input int top,
		input int bottom);
		int x0;
		int x1;
		int y0;
		int y1;
		x0 = (left < 0) ? 0 : left;
		x1 = (right > `SPR_H_VISIBLE) ? `SPR_H_VISIBLE : right;
		y0 = (top < 0) ? 0 : top;
		y1 = (bottom > `SPR_V_VISIBLE) ? `SPR_V_VISIBLE : bottom;
		if ((x1 <= x0) || (y1 <= y0))
			return 0;
		return (x1 - x0) * (y1 - y0);
	endfunction

	task automatic checkEdges(input int l, input int r, input int t, input int b);
		checkValue("leftX", int'(leftX), l);
		checkValue("rightX", int'(rightX), r);
		checkValue("topY", int'(topY), t);
		checkValue("bottomY", int'(bottomY), b);
	endtask

	//----------------------------------------------------------
	// stimulus
	//----------------------------------------------------------
	initial
	begin
		int base;
		int mode;
		int stalls;
		int expLeft;
		int expRight;
		int expTop;
		int expBottom;
		int prevLeft;
		int prevRight;
		int prevTop;
		int prevBottom;

		rstN       = 1'b0;
		cfgValid   = 1'b0;
		cfgAddr    = '0;
		cfgData    = '0;
		moveLeft   = 1'b0;
		moveRight  = 1'b0;
		jumpPress  = 1'b0;
		pixCount   = 0;
		frameCount = 0;
		updateSeen = 1'b0;
		stepsRun   = 0;
		expCol     = 0;                                        // scan restarts at 0,0
		expRow     = 0;
		prevLeft   = `SPR_DEF_START_X;                         // edges out of reset
		prevRight  = `SPR_DEF_START_X + `SPR_DEF_SIZE_X;
		prevTop    = `SPR_DEF_START_Y;
		prevBottom = `SPR_DEF_START_Y + `SPR_DEF_SIZE_Y;
		$readmemh("bench/motion_vectors.txt", vecMem);

		repeat (4) @(posedge iClk);
		#1;
		rstN = 1'b1;

		base = 0;
		while ((base + 10 <= vecDepth) && (vecMem[base] != 12'h00f))    // f ends the list
		begin
			mode      = int'(vecMem[base]);
			expLeft   = signedEdge(vecMem[base + 6]);
			expRight  = signedEdge(vecMem[base + 7]);
			expTop    = signedEdge(vecMem[base + 8]);
			expBottom = signedEdge(vecMem[base + 9]);

			// buttons first, they must stand at the frame end
			moveLeft  = vecMem[base + 3][0];
			moveRight = vecMem[base + 4][0];
			jumpPress = vecMem[base + 5][0];
			if (mode == 1)
				writeReg(spritePkg::regAddrT'(vecMem[base + 1]), vecMem[base + 2], stalls);
			else if (mode == 2)
				writeAtFrameEnd(spritePkg::regAddrT'(vecMem[base + 1]), vecMem[base + 2]);

			waitForUpdate();
			// frame just ended was drawn with the previous edges
			checkValue("pixelOnCount", frameCount,
				clippedArea(prevLeft, prevRight, prevTop, prevBottom));
			checkEdges(expLeft, expRight, expTop, expBottom);

			prevLeft   = expLeft;
			prevRight  = expRight;
			prevTop    = expTop;
			prevBottom = expBottom;
			stepsRun++;
			base += 10;
		end

		// one idle frame, grounded sprite stays put
		moveLeft  = 1'b0;
		moveRight = 1'b0;
		jumpPress = 1'b0;
		waitForUpdate();
		checkValue("pixelOnCount", frameCount,
			clippedArea(prevLeft, prevRight, prevTop, prevBottom));
		checkEdges(prevLeft, prevRight, prevTop, prevBottom);

		if (stepsRun > 0)
			$display("Everything OK");
		else
		begin
			$display("no vector steps were run");
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+design
design/spritePkg.sv
design/frameTiming.sv
design/motionRegs.sv
design/squarePosGen.sv
design/squareRaster.sv
design/spriteMotionTop.sv
bench/spriteMotionTb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the sprite motion testbench with Verilator and runs it
# exit status 0 only when the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--timescale 1ns/1ns \
	--top-module spriteMotionTb \
	--Mdir obj_dir -o simv \
	-f build.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/simv 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^Everything OK$"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1

//--- bench/motion_vectors.txt
// mode addr data left right jump, then expected leftX rightX topY bottomY, all hex
// mode 0 no write, 1 register write, 2 write issued in the frame-end cycle, f ends the list
// fall from the default start position and land on row 24
0 0 000 0 0 0 004 008 00a 00e
0 0 000 0 0 0 004 008 00b 00f
0 0 000 0 0 0 004 008 00d 011
0 0 000 0 0 0 004 008 010 014
0 0 000 0 0 0 004 008 014 018
// horizontal steps, both buttons and no button hold x
0 0 000 0 1 0 005 009 014 018
0 0 000 1 1 0 005 009 014 018
0 0 000 0 0 0 005 009 014 018
0 0 000 1 0 0 004 008 014 018
// jump arc 4 3 2 1, jumpPress while airborne ignored
0 0 000 0 0 1 004 008 010 014
0 0 000 0 0 1 004 008 00d 011
0 0 000 0 0 0 004 008 00b 00f
0 0 000 1 0 0 003 007 00a 00e
0 0 000 0 0 0 003 007 00a 00e
0 0 000 0 0 1 003 007 00b 00f
0 0 000 0 0 0 003 007 00d 011
0 0 000 0 0 0 003 007 010 014
0 0 000 0 0 0 003 007 014 018
// stepX 3, then past column 0
1 4 003 1 0 0 000 004 014 018
0 0 000 1 0 0 ffd 001 014 018
0 0 000 0 1 0 000 004 014 018
// new size and jump speed
1 2 008 0 1 0 003 00b 014 018
1 3 006 0 0 0 003 00b 012 018
1 5 003 0 0 1 003 00b 00f 015
0 0 000 0 0 0 003 00b 00d 013
0 0 000 0 0 0 003 00b 00c 012
0 0 000 0 0 0 003 00b 00c 012
0 0 000 0 0 0 003 00b 00d 013
0 0 000 0 0 0 003 00b 00f 015
0 0 000 0 0 0 003 00b 012 018
// new start point, then reload
1 0 00a 0 0 0 003 00b 012 018
1 1 002 0 0 0 003 00b 012 018
1 7 001 0 1 0 00a 012 002 008
0 0 000 0 0 0 00a 012 002 008
0 0 000 0 0 0 00a 012 003 009
// stepX 1 written in the frame-end cycle takes effect one update later
2 4 001 0 1 0 00d 015 005 00b
0 0 000 0 1 0 00e 016 008 00e
0 0 000 0 0 0 00e 016 00c 012
0 0 000 0 0 0 00e 016 010 016
0 0 000 0 0 0 00e 016 012 018
f 0 000 0 0 0 000 000 000 000
